//--- hw/ack_center.sv
`timescale 1ns/1ps

module ack_center
    import mmio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  region_t               region_i,
    input  logic                  wb_done_i,
    input  logic [data_width-1:0] wb_rdata_i,
    input  logic [data_width-1:0] key_data_i,
    input  logic                  display_ack_i,
    output logic                  wb_start_o,
    output logic                  wb_write_o,
    output logic                  key_read_o,
    output logic                  display_wen_o,
    output logic                  d_ack_o,
    output logic [data_width-1:0] load_data_o
);

    seq_state_t            state;
    seq_state_t            state_next;
    logic                  request;
    logic                  launch_ram;
    logic                  finish;
    logic [data_width-1:0] load_sel;

    assign request    = mem_read_i || mem_write_i;
    assign launch_ram = (state == S_IDLE) && request && (region_i == REG_RAM);

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (request) begin
                    if (region_i == REG_RAM) begin
                        state_next = S_WAIT_RAM;
                    end else if (region_i == REG_DISP && mem_write_i) begin
                        state_next = S_WAIT_DISP;
                    end else begin
                        // Keypad, display reads and unmapped space
                        state_next = S_WAIT_KEY;
                    end
                end
            end
            S_WAIT_RAM: begin
                if (wb_done_i) begin
                    state_next = S_DONE;
                end
            end
            S_WAIT_KEY: begin
                state_next = S_DONE;
            end
            S_WAIT_DISP: begin
                if (display_ack_i) begin
                    state_next = S_DONE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    assign finish = (state_next == S_DONE);

    // Load data source for the access that is finishing
    always_comb begin
        if (mem_read_i && region_i == REG_RAM) begin
            load_sel = wb_rdata_i;
        end else if (mem_read_i && region_i == REG_KEY) begin
            load_sel = key_data_i;
        end else begin
            load_sel = bad_read_value;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= S_IDLE;
            wb_start_o  <= 1'b0;
            wb_write_o  <= 1'b0;
            load_data_o <= '0;
        end else begin
            state      <= state_next;
            wb_start_o <= launch_ram;
            if (launch_ram) begin
                wb_write_o <= mem_write_i;
            end
            if (finish) begin
                load_data_o <= load_sel;
            end
        end
    end

    // Flag clears on the same edge that captures the keypad word
    assign key_read_o = (state == S_WAIT_KEY) && mem_read_i && (region_i == REG_KEY);

    assign display_wen_o = (state == S_WAIT_DISP);
    assign d_ack_o       = (state == S_DONE);

endmodule

//--- hw/keypad_register.sv
`timescale 1ns/1ps

module keypad_register
    import mmio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [4:0]            button_i,
    input  logic [1:0]            app_i,
    input  logic                  key_strobe_i,
    input  logic                  key_read_i,
    output logic [data_width-1:0] key_data_o
);

    logic       new_event;
    logic [4:0] button_q;
    logic [1:0] app_q;

    // Last key event fields
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            button_q <= '0;
            app_q    <= '0;
        end else if (key_strobe_i) begin
            button_q <= button_i;
            app_q    <= app_i;
        end
    end

    // A fresh strobe beats a read in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            new_event <= 1'b0;
        end else if (key_strobe_i) begin
            new_event <= 1'b1;
        end else if (key_read_i) begin
            new_event <= 1'b0;
        end
    end

    // Flag in bit 31, app in 6:5, button in 4:0
    assign key_data_o = {new_event, 24'b0, app_q, button_q};

endmodule

//--- hw/mmio_address_decoder.sv
`timescale 1ns/1ps

module mmio_address_decoder
    import mmio_pkg::*;
(
    input  logic [data_width-1:0] addr_i,
    output region_t               region_o
);

    logic hit_ram;
    logic hit_key;
    logic hit_disp;

    // RAM starts at address zero so only the upper bound matters
    assign hit_ram = (addr_i <= ram_last_addr);

    // Keypad is one word at an exact address
    assign hit_key = (addr_i == key_addr);

    // Display covers a whole aligned window
    assign hit_disp = ((addr_i & disp_mask) == disp_base);

    always_comb begin
        if (hit_ram) begin
            region_o = REG_RAM;
        end else if (hit_key) begin
            region_o = REG_KEY;
        end else if (hit_disp) begin
            region_o = REG_DISP;
        end else begin
            region_o = REG_NONE;
        end
    end

endmodule

//--- hw/mmio_pkg.sv
package mmio_pkg;

    // Width of CPU addresses and data words
    localparam int data_width = 32;

    // On-chip word SRAM at the bottom of the address space
    localparam int ram_words = 256;
    localparam int ram_index_width = $clog2(ram_words);
    localparam logic [data_width-1:0] ram_last_addr = data_width'(ram_words * 4 - 1);

    // Wait cycles the SRAM inserts before it acks
    localparam int sram_wait_cycles = 1;

    // Single keypad register word
    localparam logic [data_width-1:0] key_addr = 32'h0000_2000;

    // Display window 0x3000 to 0x3FFF
    // The mask keeps the bits that select the window
    localparam logic [data_width-1:0] disp_base = 32'h0000_3000;
    localparam logic [data_width-1:0] disp_mask = 32'hFFFF_F000;

    // Returned by reads with no data source
    localparam logic [data_width-1:0] bad_read_value = 32'hDEAD_BEEF;

    typedef enum logic [1:0] {
        REG_RAM,
        REG_KEY,
        REG_DISP,
        REG_NONE
    } region_t;

    // Access sequencer states
    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_RAM,
        S_WAIT_KEY,
        S_WAIT_DISP,
        S_DONE
    } seq_state_t;

    // Bus manager states
    typedef enum logic {
        WB_IDLE,
        WB_BUS
    } wb_state_t;

endpackage

//--- hw/mmio_subsystem.sv
`timescale 1ns/1ps

module mmio_subsystem
    import mmio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // CPU data port
    input  logic [data_width-1:0] addr_i,
    input  logic [data_width-1:0] store_data_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    output logic                  d_ack_o,
    output logic [data_width-1:0] load_data_o,

    // Keypad
    input  logic [4:0]            button_i,
    input  logic [1:0]            app_i,
    input  logic                  key_strobe_i,

    // Display
    input  logic                  display_ack_i,
    output logic [data_width-1:0] display_addr_o,
    output logic [data_width-1:0] display_data_o,
    output logic                  display_wen_o
);

    region_t               region;
    logic [data_width-1:0] key_data;
    logic                  key_read;
    logic                  wb_start;
    logic                  wb_write;
    logic                  wb_done;
    logic [data_width-1:0] wb_rdata;

    // Bus between manager and SRAM
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [data_width-1:0] wb_adr;
    logic [data_width-1:0] wb_dat_m2s;
    logic [data_width-1:0] wb_dat_s2m;
    logic                  wb_ack;

    mmio_address_decoder mmio_address_decoder_i (
        .addr_i   (addr_i),
        .region_o (region)
    );

    keypad_register keypad_register_i (
        .clk          (clk),
        .reset        (reset),
        .button_i     (button_i),
        .app_i        (app_i),
        .key_strobe_i (key_strobe_i),
        .key_read_i   (key_read),
        .key_data_o   (key_data)
    );

    ack_center ack_center_i (
        .clk           (clk),
        .reset         (reset),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .region_i      (region),
        .wb_done_i     (wb_done),
        .wb_rdata_i    (wb_rdata),
        .key_data_i    (key_data),
        .display_ack_i (display_ack_i),
        .wb_start_o    (wb_start),
        .wb_write_o    (wb_write),
        .key_read_o    (key_read),
        .display_wen_o (display_wen_o),
        .d_ack_o       (d_ack_o),
        .load_data_o   (load_data_o)
    );

    // CPU request is held for the whole access
    wb_manager wb_manager_i (
        .clk      (clk),
        .reset    (reset),
        .start_i  (wb_start),
        .write_i  (wb_write),
        .addr_i   (addr_i),
        .wdata_i  (store_data_i),
        .rdata_o  (wb_rdata),
        .done_o   (wb_done),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_m2s),
        .wb_ack_i (wb_ack),
        .wb_dat_i (wb_dat_s2m)
    );

    wb_sram wb_sram_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_m2s),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_s2m)
    );

    // Display sees the CPU request directly
    assign display_addr_o = addr_i;
    assign display_data_o = store_data_i;

endmodule

//--- hw/wb_manager.sv
`timescale 1ns/1ps

module wb_manager
    import mmio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // Request side
    input  logic                  start_i,
    input  logic                  write_i,
    input  logic [data_width-1:0] addr_i,
    input  logic [data_width-1:0] wdata_i,
    output logic [data_width-1:0] rdata_o,
    output logic                  done_o,

    // Bus side
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic                  wb_we_o,
    output logic [data_width-1:0] wb_adr_o,
    output logic [data_width-1:0] wb_dat_o,
    input  logic                  wb_ack_i,
    input  logic [data_width-1:0] wb_dat_i
);

    wb_state_t state;
    wb_state_t state_next;
    logic      launch;
    logic      bus_end;

    assign launch  = (state == WB_IDLE) && start_i;
    assign bus_end = (state == WB_BUS) && wb_ack_i;

    always_comb begin
        state_next = state;
        case (state)
            WB_IDLE: begin
                if (start_i) begin
                    state_next = WB_BUS;
                end
            end
            WB_BUS: begin
                // Hold the cycle until the subordinate answers
                if (wb_ack_i) begin
                    state_next = WB_IDLE;
                end
            end
            default: begin
                state_next = WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= WB_IDLE;
            done_o <= 1'b0;
        end else begin
            state  <= state_next;
            done_o <= bus_end;
        end
    end

    // Request captured at launch and held for the whole cycle
    always_ff @(posedge clk) begin
        if (launch) begin
            wb_we_o  <= write_i;
            wb_adr_o <= addr_i;
            wb_dat_o <= wdata_i;
        end
    end

    // Read word valid together with done_o
    always_ff @(posedge clk) begin
        if (bus_end) begin
            rdata_o <= wb_dat_i;
        end
    end

    // Single access per cycle so strobe follows cycle
    assign wb_cyc_o = (state == WB_BUS);
    assign wb_stb_o = (state == WB_BUS);

endmodule

//--- hw/wb_sram.sv
`timescale 1ns/1ps

module wb_sram
    import mmio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [data_width-1:0] wb_adr_i,
    input  logic [data_width-1:0] wb_dat_i,
    output logic                  wb_ack_o,
    output logic [data_width-1:0] wb_dat_o
);

    logic [data_width-1:0]      mem [ram_words];
    logic [3:0]                 wait_count;
    logic [ram_index_width-1:0] index;
    logic                       active;
    logic                       fire;

    assign index  = wb_adr_i[ram_index_width+1:2];
    assign active = wb_cyc_i && wb_stb_i;

    // Access happens once the wait count is reached and no ack is pending
    assign fire = active && !wb_ack_o && (wait_count == 4'(sram_wait_cycles));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_count <= '0;
            wb_ack_o   <= 1'b0;
        end else if (!active || wb_ack_o) begin
            // Ack lasts one cycle and the count restarts
            wait_count <= '0;
            wb_ack_o   <= 1'b0;
        end else if (fire) begin
            wb_ack_o <= 1'b1;
        end else begin
            wait_count <= wait_count + 4'd1;
        end
    end

    // Storage array and read port
    always_ff @(posedge clk) begin
        if (fire) begin
            if (wb_we_i) begin
                mem[index] <= wb_dat_i;
            end else begin
                wb_dat_o <= mem[index];
            end
        end
    end

endmodule

//--- mmio_subsystem.f
hw/mmio_pkg.sv
hw/mmio_address_decoder.sv
hw/keypad_register.sv
hw/wb_manager.sv
hw/wb_sram.sv
hw/ack_center.sv
hw/mmio_subsystem.sv
verification/mmio_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MMIO hub simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f mmio_subsystem.f \
    --top-module mmio_subsystem_tb -o sim_mmio_subsystem

output=$(./obj_dir/sim_mmio_subsystem)
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- verification/mmio_subsystem_tb.sv
`timescale 1ns/1ps

module mmio_subsystem_tb;

    localparam int access_timeout = 40;
    localparam logic [31:0] no_source_value = 32'hDEAD_BEEF;

    typedef enum logic [3:0] {
        OP_RAM_WR, OP_RAM_RD, OP_KEY_STROBE,
        OP_KEY_RD, OP_KEY_WR, OP_DISP_WR,
        OP_DISP_RD, OP_NONE_RD, OP_NONE_WR
    } op_t;

    typedef struct {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [4:0]  button;
        logic [1:0]  app;
        int          delay;
        logic [31:0] expected;
    } entry_t;

    logic        clk;
    logic        reset;
    logic [31:0] addr_i;
    logic [31:0] store_data_i;
    logic        mem_read_i;
    logic        mem_write_i;
    logic [4:0]  button_i;
    logic [1:0]  app_i;
    logic        key_strobe_i;
    logic        display_ack_i;
    logic        d_ack_o;
    logic [31:0] load_data_o;
    logic [31:0] display_addr_o;
    logic [31:0] display_data_o;
    logic        display_wen_o;

    // Stimulus table and reference models
    entry_t      tests[$];
    logic [31:0] ram_model [256];
    logic        key_flag;
    logic [4:0]  key_button;
    logic [1:0]  key_app;
    int          seed;
    int          errors;
    int          passed;
    int          failed;
    bit          timed_out;

    mmio_subsystem mmio_subsystem_i (
        .clk            (clk),
        .reset          (reset),
        .addr_i         (addr_i),
        .store_data_i   (store_data_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .d_ack_o        (d_ack_o),
        .load_data_o    (load_data_o),
        .button_i       (button_i),
        .app_i          (app_i),
        .key_strobe_i   (key_strobe_i),
        .display_ack_i  (display_ack_i),
        .display_addr_o (display_addr_o),
        .display_data_o (display_data_o),
        .display_wen_o  (display_wen_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    function automatic int pick_delay();
        return ($random(seed) & 3) + 1;
    endfunction

    // Appends one entry and advances the models in table order
    function automatic void add_entry(input op_t op, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [4:0] button,
                                      input logic [1:0] app);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.button   = button;
        e.app      = app;
        e.delay    = 0;
        e.expected = no_source_value;
        case (op)
            OP_RAM_WR: ram_model[addr[9:2]] = data;
            OP_RAM_RD: e.expected = ram_model[addr[9:2]];
            OP_KEY_STROBE: begin
                key_flag   = 1'b1;
                key_button = button;
                key_app    = app;
            end
            OP_KEY_RD: begin
                e.expected      = '0;
                e.expected[31]  = key_flag;
                e.expected[6:5] = key_app;
                e.expected[4:0] = key_button;
                key_flag        = 1'b0;
            end
            OP_DISP_WR: e.delay = pick_delay();
            default: ;
        endcase
        tests.push_back(e);
    endfunction

    function automatic void build_tests();
        add_entry(OP_RAM_WR, 32'h0000_0000, $random(seed), 5'h00, 2'h0);
        add_entry(OP_RAM_WR, 32'h0000_03FC, $random(seed), 5'h00, 2'h0);
        add_entry(OP_RAM_WR, 32'h0000_0004, 32'h1234_5678, 5'h00, 2'h0);
        add_entry(OP_RAM_WR, 32'h0000_0008, $random(seed), 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0000, 32'h0, 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_03FC, 32'h0, 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0004, 32'h0, 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0008, 32'h0, 5'h00, 2'h0);
        add_entry(OP_RAM_WR, 32'h0000_0004, $random(seed), 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0004, 32'h0, 5'h00, 2'h0);
        add_entry(OP_KEY_STROBE, 32'h0, 32'h0, 5'h13, 2'h2);
        add_entry(OP_KEY_RD, 32'h0000_2000, 32'h0, 5'h00, 2'h0);
        add_entry(OP_KEY_RD, 32'h0000_2000, 32'h0, 5'h00, 2'h0);
        // Display addresses alias RAM words 1 and 255
        add_entry(OP_DISP_WR, 32'h0000_3004, $random(seed), 5'h00, 2'h0);
        add_entry(OP_DISP_WR, 32'h0000_3FFC, $random(seed), 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0004, 32'h0, 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_03FC, 32'h0, 5'h00, 2'h0);
        add_entry(OP_NONE_RD, 32'h0000_0400, 32'h0, 5'h00, 2'h0);
        add_entry(OP_DISP_RD, 32'h0000_3010, 32'h0, 5'h00, 2'h0);
        add_entry(OP_KEY_WR, 32'h0000_2000, 32'hFFFF_FFFF, 5'h00, 2'h0);
        add_entry(OP_KEY_RD, 32'h0000_2000, 32'h0, 5'h00, 2'h0);
        add_entry(OP_KEY_STROBE, 32'h0, 32'h0, 5'h1F, 2'h1);
        add_entry(OP_KEY_WR, 32'h0000_2000, 32'h0000_0000, 5'h00, 2'h0);
        add_entry(OP_KEY_RD, 32'h0000_2000, 32'h0, 5'h00, 2'h0);
        // Unmapped writes whose low bits hit RAM words 0 and 2
        add_entry(OP_NONE_WR, 32'h0000_1000, $random(seed), 5'h00, 2'h0);
        add_entry(OP_NONE_WR, 32'h8000_0008, $random(seed), 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0000, 32'h0, 5'h00, 2'h0);
        add_entry(OP_RAM_RD, 32'h0000_0008, 32'h0, 5'h00, 2'h0);
        add_entry(OP_NONE_RD, 32'hFFFF_FFFC, 32'h0, 5'h00, 2'h0);
    endfunction

    function automatic string op_name(input op_t op);
        case (op)
            OP_RAM_WR:     return "ram write";
            OP_RAM_RD:     return "ram read";
            OP_KEY_STROBE: return "keypad strobe";
            OP_KEY_RD:     return "keypad read";
            OP_KEY_WR:     return "keypad write";
            OP_DISP_WR:    return "display write";
            OP_DISP_RD:    return "display read";
            OP_NONE_RD:    return "unmapped read";
            default:       return "unmapped write";
        endcase
    endfunction

    task automatic check_idle_outputs();
        check_value("d_ack_o", {31'b0, d_ack_o}, 32'h0);
        check_value("display_wen_o", {31'b0, display_wen_o}, 32'h0);
        check_value("load_data_o", load_data_o, 32'h0);
    endtask

    task automatic strobe_key(input logic [4:0] button, input logic [1:0] app);
        button_i     = button;
        app_i        = app;
        key_strobe_i = 1'b1;
        @(posedge clk);
        #5;
        key_strobe_i = 1'b0;
    endtask

    // One CPU access; edges are counted from the request
    task automatic run_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input int disp_delay,
                              output logic [31:0] load, output int ack_cycle,
                              output int wen_cycles);
        int n;
        bit seen;
        n            = 0;
        seen         = 1'b0;
        load         = '0;
        ack_cycle    = 0;
        wen_cycles   = 0;
        addr_i       = addr;
        store_data_i = data;
        mem_write_i  = wr;
        mem_read_i   = ~wr;
        while (!seen && n < access_timeout) begin
            @(posedge clk);
            #5;
            n++;
            if (d_ack_o) begin
                seen          = 1'b1;
                ack_cycle     = n;
                load          = load_data_o;
                display_ack_i = 1'b0;
            end else if (display_wen_o) begin
                wen_cycles++;
                check_value("display_addr_o", display_addr_o, addr);
                check_value("display_data_o", display_data_o, data);
                // Ack is seen at the next edge, ending the enable
                display_ack_i = (wen_cycles >= disp_delay);
            end
        end
        if (!seen) begin
            $display("Timeout: no acknowledge within %0d cycles for the access at 0x%08h",
                     access_timeout, addr);
            timed_out = 1'b1;
            errors++;
        end
        // Request is removed in the cycle after the acknowledge
        @(posedge clk);
        #5;
        if (seen) begin
            check_value("d_ack_o", {31'b0, d_ack_o}, 32'h0);
        end
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        display_ack_i = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input logic [31:0] addr,
                               input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("test %0d %s at 0x%08h: ok", num, name, addr);
        end else begin
            failed++;
            $display("test %0d %s at 0x%08h: error", num, name, addr);
        end
    endtask

    initial begin
        entry_t      e;
        logic [31:0] load;
        int          ack_cycle;
        int          wen_cycles;
        int          errors_before;
        seed          = 32'h633f3c87;
        errors        = 0;
        passed        = 0;
        failed        = 0;
        timed_out     = 1'b0;
        reset         = 1'b1;
        addr_i        = '0;
        store_data_i  = '0;
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        button_i      = '0;
        app_i         = '0;
        key_strobe_i  = 1'b0;
        display_ack_i = 1'b0;
        key_flag      = 1'b0;
        key_button    = '0;
        key_app       = '0;
        ack_cycle     = 0;
        wen_cycles    = 0;
        build_tests();

        // Outputs stay quiet through reset and a few idle cycles
        errors_before = errors;
        repeat (16) begin
            @(posedge clk);
            #5;
            check_idle_outputs();
        end
        reset = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #5;
            check_idle_outputs();
        end
        report_test(0, "reset and idle", 32'h0, errors_before);

        for (int i = 0; i < tests.size(); i++) begin
            e = tests[i];
            errors_before = errors;
            case (e.op)
                OP_KEY_STROBE: strobe_key(e.button, e.app);
                OP_RAM_WR, OP_KEY_WR, OP_DISP_WR, OP_NONE_WR: begin
                    run_access(1'b1, e.addr, e.data, e.delay, load, ack_cycle, wen_cycles);
                end
                default: begin
                    run_access(1'b0, e.addr, e.data, e.delay, load, ack_cycle, wen_cycles);
                end
            endcase
            // Register-style accesses have a fixed two-edge latency
            if (e.op inside {OP_KEY_RD, OP_KEY_WR, OP_DISP_RD, OP_NONE_RD, OP_NONE_WR}) begin
                check_value("d_ack_o latency", ack_cycle, 32'd2);
            end
            if (e.op inside {OP_RAM_RD, OP_KEY_RD, OP_DISP_RD, OP_NONE_RD}) begin
                check_value("load_data_o", load, e.expected);
            end
            if (e.op == OP_DISP_WR) begin
                check_value("display_wen_o cycles", wen_cycles, e.delay);
                check_value("d_ack_o latency", ack_cycle, e.delay + 1);
            end
            report_test(i + 1, op_name(e.op), e.addr, errors_before);
            if (timed_out) begin
                break;
            end
        end

        $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
